/* common/regblk_pkg.sv */
`default_nettype none

package regblk_pkg;

  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;

  // Address map.
  localparam addr_t BASE_ADDR     = 16'h1000;
  localparam data_t DEFAULT_RDATA = 32'hDEAD_BEAF;

  localparam addr_t OFS_CTRL     = 16'h0000;
  localparam addr_t OFS_TRIG     = 16'h0004;
  localparam addr_t OFS_IRQ_STAT = 16'h0008;
  localparam addr_t OFS_IRQ_MASK = 16'h000C;
  localparam addr_t OFS_COUNT    = 16'h0010;

  typedef enum logic [2:0] {
    REG_CTRL,
    REG_TRIG,
    REG_IRQ_STAT,
    REG_IRQ_MASK,
    REG_COUNT,
    REG_NONE
  } reg_id_e;

  localparam int N_TRIG = 4;
  localparam int N_IRQ  = 4;
  localparam int CNT_W  = 8;

  typedef logic [N_TRIG-1:0] trig_t;
  typedef logic [N_IRQ-1:0]  irq_t;
  typedef logic [CNT_W-1:0]  cnt_t;

  // Control register: mode in 7:0, counter enable in bit 8.
  localparam data_t CTRL_RESET      = 32'h0000_0005;
  localparam data_t CTRL_MASK       = 32'h0000_01FF;
  localparam int    CTRL_CNT_EN_BIT = 8;

endpackage

`default_nettype wire

/* regblk/apb_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_decoder (
  input  wire                      clk,
  input  wire                      i_rst_n,
  input  wire                      i_psel,
  input  wire                      i_penable,
  input  wire regblk_pkg::addr_t   i_paddr,
  input  wire                      i_pwrite,
  input  wire regblk_pkg::strb_t   i_pstrb,
  input  wire regblk_pkg::data_t   i_pwdata,
  input  wire regblk_pkg::data_t   i_ctrl,
  input  wire regblk_pkg::irq_t    i_irq_stat,
  input  wire regblk_pkg::irq_t    i_irq_mask,
  input  wire regblk_pkg::cnt_t    i_count,
  output logic                     o_pready,
  output regblk_pkg::data_t        o_prdata,
  output logic                     o_pslverr,
  output logic                     o_wr_en,
  output regblk_pkg::reg_id_e      o_wr_id,
  output regblk_pkg::data_t        o_wr_data,
  output regblk_pkg::data_t        o_wr_bmask
);

  import regblk_pkg::*;

  addr_t   offset;
  reg_id_e reg_id;
  logic    access;
  logic    err;

  assign offset = i_paddr - BASE_ADDR;

  always_comb begin
    case (offset)
      OFS_CTRL:     reg_id = REG_CTRL;
      OFS_TRIG:     reg_id = REG_TRIG;
      OFS_IRQ_STAT: reg_id = REG_IRQ_STAT;
      OFS_IRQ_MASK: reg_id = REG_IRQ_MASK;
      OFS_COUNT:    reg_id = REG_COUNT;
      default:      reg_id = REG_NONE;
    endcase
  end

  assign access = i_psel && i_penable;

  // COUNT is read-only, TRIG is write-only.
  assign err = (reg_id == REG_NONE) ||
               (i_pwrite && (reg_id == REG_COUNT)) ||
               (!i_pwrite && (reg_id == REG_TRIG));

  assign o_pready  = i_psel;
  assign o_pslverr = access && err;

  always_comb begin
    case (reg_id)
      REG_CTRL:     o_prdata = i_ctrl;
      REG_IRQ_STAT: o_prdata = data_t'(i_irq_stat);
      REG_IRQ_MASK: o_prdata = data_t'(i_irq_mask);
      REG_COUNT:    o_prdata = data_t'(i_count);
      REG_TRIG:     o_prdata = '0;
      default:      o_prdata = DEFAULT_RDATA;
    endcase
  end

  assign o_wr_en   = access && i_pwrite && !err;
  assign o_wr_id   = reg_id;
  assign o_wr_data = i_pwdata;

  always_comb begin
    for (int b = 0; b < STRB_W; b++) begin
      o_wr_bmask[b*8 +: 8] = {8{i_pstrb[b]}};
    end
  end

  // Access phase is always preceded by selection.
  a_penable_needs_psel: assert property (
    @(posedge clk) disable iff (!i_rst_n) i_penable |-> i_psel
  );

endmodule

`default_nettype wire

/* regblk/ctrl_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs (
  input  wire                       clk,
  input  wire                       i_rst_n,
  input  wire                       i_wr_en,
  input  wire regblk_pkg::reg_id_e  i_wr_id,
  input  wire regblk_pkg::data_t    i_wr_data,
  input  wire regblk_pkg::data_t    i_wr_bmask,
  output regblk_pkg::data_t         o_ctrl,
  output regblk_pkg::trig_t         o_trigger
);

  import regblk_pkg::*;

  data_t ctrl_q;
  data_t ctrl_bits;
  trig_t trig_q;
  logic  ctrl_wr;
  logic  trig_wr;

  assign ctrl_wr   = i_wr_en && (i_wr_id == REG_CTRL);
  assign trig_wr   = i_wr_en && (i_wr_id == REG_TRIG);
  assign ctrl_bits = CTRL_MASK & i_wr_bmask;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ctrl_q <= CTRL_RESET;
    end else if (ctrl_wr) begin
      ctrl_q <= (ctrl_q & ~ctrl_bits) | (i_wr_data & ctrl_bits);
    end
  end

  // Pulses last one cycle after the write.
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      trig_q <= '0;
    end else if (trig_wr) begin
      trig_q <= i_wr_data[N_TRIG-1:0];
    end else begin
      trig_q <= '0;
    end
  end

  assign o_ctrl    = ctrl_q;
  assign o_trigger = trig_q;

  a_trigger_single_cycle: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    ((o_trigger != '0) && !trig_wr) |=> (o_trigger == '0)
  );

endmodule

`default_nettype wire

/* regblk/irq_status.sv */
`timescale 1ns/1ps
`default_nettype none

module irq_status (
  input  wire                       clk,
  input  wire                       i_rst_n,
  input  wire                       i_wr_en,
  input  wire regblk_pkg::reg_id_e  i_wr_id,
  input  wire regblk_pkg::data_t    i_wr_data,
  input  wire regblk_pkg::data_t    i_wr_bmask,
  input  wire regblk_pkg::irq_t     i_irq_set,
  output regblk_pkg::irq_t          o_irq_stat,
  output regblk_pkg::irq_t          o_irq_mask,
  output logic                      o_irq
);

  import regblk_pkg::*;

  irq_t stat_q;
  irq_t mask_q;
  irq_t clr;
  irq_t wbits;

  assign wbits = i_wr_bmask[N_IRQ-1:0];

  always_comb begin
    clr = '0;
    if (i_wr_en && (i_wr_id == REG_IRQ_STAT)) begin
      clr = i_wr_data[N_IRQ-1:0] & wbits;
    end
  end

  // Hardware set wins over a clear in the same cycle.
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      stat_q <= '0;
    end else begin
      stat_q <= (stat_q & ~clr) | i_irq_set;
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      mask_q <= '0;
    end else if (i_wr_en && (i_wr_id == REG_IRQ_MASK)) begin
      mask_q <= (mask_q & ~wbits) | (i_wr_data[N_IRQ-1:0] & wbits);
    end
  end

  assign o_irq_stat = stat_q;
  assign o_irq_mask = mask_q;
  assign o_irq      = |(stat_q & mask_q);

  a_set_reaches_status: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    (i_irq_set != '0) |=> ((o_irq_stat & $past(i_irq_set)) == $past(i_irq_set))
  );

endmodule

`default_nettype wire

/* regblk/event_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module event_counter (
  input  wire                     clk,
  input  wire                     i_rst_n,
  input  wire                     i_enable,
  input  wire                     i_clear,
  input  wire                     i_up,
  input  wire                     i_down,
  output regblk_pkg::cnt_t        o_count
);

  import regblk_pkg::*;

  cnt_t count_q;

  // Clear first, then a single-direction step; wraps modulo 256.
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      count_q <= '0;
    end else if (i_clear) begin
      count_q <= '0;
    end else if (i_enable && i_up && !i_down) begin
      count_q <= count_q + cnt_t'(1);
    end else if (i_enable && i_down && !i_up) begin
      count_q <= count_q - cnt_t'(1);
    end
  end

  assign o_count = count_q;

  a_hold_when_disabled: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    (!i_clear && !i_enable) |=> $stable(o_count)
  );

endmodule

`default_nettype wire

/* regblk/regblk_top.sv */
`timescale 1ns/1ps
`default_nettype none

module regblk_top (
  input  wire                     clk,
  input  wire                     i_rst_n,
  input  wire                     i_psel,
  input  wire                     i_penable,
  input  wire regblk_pkg::addr_t  i_paddr,
  input  wire                     i_pwrite,
  input  wire regblk_pkg::strb_t  i_pstrb,
  input  wire regblk_pkg::data_t  i_pwdata,
  output logic                    o_pready,
  output regblk_pkg::data_t       o_prdata,
  output logic                    o_pslverr,
  input  wire regblk_pkg::irq_t   i_irq_set,
  input  wire                     i_cnt_up,
  input  wire                     i_cnt_down,
  output regblk_pkg::data_t       o_ctrl,
  output regblk_pkg::trig_t       o_trigger,
  output logic                    o_irq,
  output regblk_pkg::cnt_t        o_count
);

  import regblk_pkg::*;

  logic    wr_en;
  reg_id_e wr_id;
  data_t   wr_data;
  data_t   wr_bmask;
  irq_t    irq_stat;
  irq_t    irq_mask;

  apb_decoder apb_decoder_i (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_psel     (i_psel),
    .i_penable  (i_penable),
    .i_paddr    (i_paddr),
    .i_pwrite   (i_pwrite),
    .i_pstrb    (i_pstrb),
    .i_pwdata   (i_pwdata),
    .i_ctrl     (o_ctrl),
    .i_irq_stat (irq_stat),
    .i_irq_mask (irq_mask),
    .i_count    (o_count),
    .o_pready   (o_pready),
    .o_prdata   (o_prdata),
    .o_pslverr  (o_pslverr),
    .o_wr_en    (wr_en),
    .o_wr_id    (wr_id),
    .o_wr_data  (wr_data),
    .o_wr_bmask (wr_bmask)
  );

  ctrl_regs ctrl_regs_i (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_wr_en    (wr_en),
    .i_wr_id    (wr_id),
    .i_wr_data  (wr_data),
    .i_wr_bmask (wr_bmask),
    .o_ctrl     (o_ctrl),
    .o_trigger  (o_trigger)
  );

  irq_status irq_status_i (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_wr_en    (wr_en),
    .i_wr_id    (wr_id),
    .i_wr_data  (wr_data),
    .i_wr_bmask (wr_bmask),
    .i_irq_set  (i_irq_set),
    .o_irq_stat (irq_stat),
    .o_irq_mask (irq_mask),
    .o_irq      (o_irq)
  );

  // Enable from the control register, clear from trigger bit 0.
  event_counter event_counter_i (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_enable (o_ctrl[CTRL_CNT_EN_BIT]),
    .i_clear  (o_trigger[0]),
    .i_up     (i_cnt_up),
    .i_down   (i_cnt_down),
    .o_count  (o_count)
  );

endmodule

`default_nettype wire

/* test/tb_regblk.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_regblk;

  import regblk_pkg::*;

  localparam int N_CTRL     = 20;
  localparam int N_TRIGS    = 8;
  localparam int N_MIXED    = 40;
  localparam int N_ERRS     = 16;
  localparam int N_OPS      = 7 + 2 * N_CTRL + N_TRIGS + 2 * N_MIXED + N_ERRS;
  localparam int TIMEOUT_NS = (3 * N_OPS + N_TRIGS + 8) * 8 + 400;

  logic    clk = 1'b0;
  logic    rst_n, psel, penable, pwrite, hw_rand;
  addr_t   paddr;
  strb_t   pstrb;
  data_t   pwdata, prdata, o_ctrl;
  logic    pready, pslverr, o_irq;
  irq_t    irq_set = '0;
  logic    cnt_up = 1'b0;
  logic    cnt_down = 1'b0;
  trig_t   o_trigger;
  cnt_t    o_count;
  // Register model.
  data_t   m_ctrl;
  trig_t   m_trig;
  irq_t    m_stat, m_mask;
  cnt_t    m_count;
  int      errors = 0;
  int      n_pass = 0;
  int      n_fail = 0;
  int      mark;
  data_t   snap_ctrl, d;
  irq_t    snap_stat, snap_mask;
  cnt_t    snap_count;
  data_t   last_rdata;

  always #4 clk = ~clk;

  regblk_top dut_i (
    .clk (clk), .i_rst_n (rst_n), .i_psel (psel), .i_penable (penable), .i_paddr (paddr),
    .i_pwrite (pwrite), .i_pstrb (pstrb), .i_pwdata (pwdata), .o_pready (pready),
    .o_prdata (prdata), .o_pslverr (pslverr), .i_irq_set (irq_set), .i_cnt_up (cnt_up),
    .i_cnt_down (cnt_down), .o_ctrl (o_ctrl), .o_trigger (o_trigger), .o_irq (o_irq),
    .o_count (o_count)
  );

  function automatic reg_id_e reg_of(input addr_t addr);
    addr_t ofs;
    ofs = addr - BASE_ADDR;
    if (ofs == OFS_CTRL) return REG_CTRL;
    if (ofs == OFS_TRIG) return REG_TRIG;
    if (ofs == OFS_IRQ_STAT) return REG_IRQ_STAT;
    if (ofs == OFS_IRQ_MASK) return REG_IRQ_MASK;
    if (ofs == OFS_COUNT) return REG_COUNT;
    return REG_NONE;
  endfunction

  function automatic logic is_err(input reg_id_e id, input logic wr);
    return (id == REG_NONE) || (wr && id == REG_COUNT) || (!wr && id == REG_TRIG);
  endfunction

  function automatic data_t byte_mask(input strb_t strb);
    data_t m;
    m = '0;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) m[8*b +: 8] = 8'hFF;
    end
    return m;
  endfunction

  // Model follows the same edge as the DUT, from the driven bus values.
  always @(posedge clk or negedge rst_n) begin : model_step
    reg_id_e id;
    logic    wr_ok;
    data_t   bits;
    irq_t    clr;
    if (!rst_n) begin
      m_ctrl  <= CTRL_RESET;
      m_trig  <= '0;
      m_stat  <= '0;
      m_mask  <= '0;
      m_count <= '0;
    end else begin
      id    = reg_of(paddr);
      wr_ok = psel && penable && pwrite && !is_err(id, 1'b1);
      bits  = byte_mask(pstrb);
      clr   = (wr_ok && id == REG_IRQ_STAT) ? (pwdata[N_IRQ-1:0] & bits[N_IRQ-1:0]) : '0;
      if (wr_ok && id == REG_CTRL) begin
        m_ctrl <= (m_ctrl & ~(bits & CTRL_MASK)) | (pwdata & bits & CTRL_MASK);
      end
      if (wr_ok && id == REG_IRQ_MASK) begin
        m_mask <= (m_mask & ~bits[N_IRQ-1:0]) | (pwdata[N_IRQ-1:0] & bits[N_IRQ-1:0]);
      end
      m_trig <= (wr_ok && id == REG_TRIG) ? pwdata[N_TRIG-1:0] : '0;
      m_stat <= (m_stat & ~clr) | irq_set;
      if (m_trig[0]) m_count <= '0;
      else if (m_ctrl[CTRL_CNT_EN_BIT] && cnt_up && !cnt_down) m_count <= m_count + cnt_t'(1);
      else if (m_ctrl[CTRL_CNT_EN_BIT] && cnt_down && !cnt_up) m_count <= m_count - cnt_t'(1);
    end
  end

  task automatic check_data(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_resp(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_irq(input irq_t got, input irq_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_trig(input trig_t got, input trig_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input cnt_t got, input cnt_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  // Falling edge: compare outputs, then drive new hardware events.
  task automatic next_cycle();
    @(negedge clk);
    if (rst_n) begin
      check_data(o_ctrl, m_ctrl, "o_ctrl");
      check_trig(o_trigger, m_trig, "o_trigger");
      check_resp(o_irq, |(m_stat & m_mask), "o_irq");
      check_count(o_count, m_count, "o_count");
    end
    irq_set  = hw_rand ? irq_t'($urandom) : '0;
    cnt_up   = hw_rand && $urandom_range(1, 0) == 1;
    cnt_down = hw_rand && $urandom_range(1, 0) == 1;
  endtask

  task automatic apb_access(input addr_t addr, input logic wr, input data_t data);
    reg_id_e id;
    logic    err;
    id  = reg_of(addr);
    err = is_err(id, wr);
    next_cycle();
    psel    = 1'b1;
    penable = 1'b0;
    paddr   = addr;
    pwrite  = wr;
    pwdata  = data;
    pstrb   = strb_t'($urandom);
    next_cycle();
    penable = 1'b1;
    #2;
    last_rdata = prdata;
    check_resp(pready, 1'b1, "pready");
    check_resp(pslverr, err, "pslverr");
    if (!wr && id == REG_NONE) begin
      check_data(prdata, DEFAULT_RDATA, "unmapped read");
    end else if (!wr && !err) begin
      case (id)
        REG_IRQ_STAT: check_irq(prdata[N_IRQ-1:0], m_stat, "IRQ_STAT read");
        REG_IRQ_MASK: check_irq(prdata[N_IRQ-1:0], m_mask, "IRQ_MASK read");
        REG_COUNT:    check_count(prdata[CNT_W-1:0], m_count, "COUNT read");
        default:      check_data(prdata, m_ctrl, "CTRL read");
      endcase
    end
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic report_test(input string name, input int start_errs);
    if (errors == start_errs) begin
      $display("PASS  %s", name);
      n_pass++;
    end else begin
      $display("FAIL  %s (%0d errors)", name, errors - start_errs);
      n_fail++;
    end
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: tests still running after %0d ns", TIMEOUT_NS);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    void'($urandom(22100));
    {rst_n, psel, penable, pwrite, hw_rand} = '0;
    paddr  = '0;
    pstrb  = '0;
    pwdata = '0;
    repeat (4) next_cycle();
    rst_n = 1'b1;

    mark = errors;
    check_data(o_ctrl, CTRL_RESET, "o_ctrl after reset");
    check_trig(o_trigger, '0, "o_trigger after reset");
    check_resp(o_irq, 1'b0, "o_irq after reset");
    for (int i = 0; i < 5; i++) apb_access(BASE_ADDR + addr_t'(4 * i), 1'b0, '0);
    report_test("reset values", mark);

    mark = errors;
    for (int i = 0; i < N_CTRL; i++) begin
      apb_access(BASE_ADDR + OFS_CTRL, 1'b1, data_t'($urandom));
      apb_access(BASE_ADDR + OFS_CTRL, 1'b0, '0);
    end
    report_test("control byte strobes", mark);

    mark = errors;
    for (int i = 0; i < N_TRIGS; i++) begin
      d = data_t'($urandom);
      apb_access(BASE_ADDR + OFS_TRIG, 1'b1, d);
      check_trig(o_trigger, d[N_TRIG-1:0], "trigger pulse");
      next_cycle();
      check_trig(o_trigger, '0, "trigger after pulse");
    end
    report_test("trigger pulses", mark);

    mark = errors;
    hw_rand = 1'b1;
    for (int i = 0; i < N_MIXED; i++) begin
      case ($urandom_range(2, 0))
        0:       apb_access(BASE_ADDR + OFS_IRQ_STAT, 1'b1, data_t'($urandom));
        1:       apb_access(BASE_ADDR + OFS_IRQ_MASK, 1'b1, data_t'($urandom));
        default: apb_access(BASE_ADDR + OFS_IRQ_STAT, 1'b0, '0);
      endcase
    end
    report_test("interrupt status and mask", mark);

    mark = errors;
    for (int i = 0; i < N_MIXED; i++) begin
      case ($urandom_range(2, 0))
        0:       apb_access(BASE_ADDR + OFS_CTRL, 1'b1, data_t'($urandom));
        1:       apb_access(BASE_ADDR + OFS_TRIG, 1'b1, data_t'($urandom));
        default: apb_access(BASE_ADDR + OFS_COUNT, 1'b0, '0);
      endcase
    end
    report_test("event counter", mark);

    mark = errors;
    hw_rand = 1'b0;
    repeat (2) next_cycle();
    snap_ctrl  = m_ctrl;
    snap_stat  = m_stat;
    snap_mask  = m_mask;
    snap_count = m_count;
    for (int i = 0; i < N_ERRS; i++) begin
      d = data_t'($urandom);
      case ($urandom_range(3, 0))
        0: apb_access(BASE_ADDR + 16'h0020 + addr_t'($urandom_range(255, 0) * 4), 1'b0, d);
        1: apb_access(BASE_ADDR + addr_t'($urandom_range(3, 1)), 1'b1, d);
        2: apb_access(BASE_ADDR + OFS_COUNT, 1'b1, d);
        default: apb_access(BASE_ADDR + OFS_TRIG, 1'b0, d);
      endcase
    end
    apb_access(BASE_ADDR + OFS_IRQ_STAT, 1'b0, '0);
    check_irq(last_rdata[N_IRQ-1:0], snap_stat, "IRQ_STAT after error accesses");
    apb_access(BASE_ADDR + OFS_IRQ_MASK, 1'b0, '0);
    check_irq(last_rdata[N_IRQ-1:0], snap_mask, "IRQ_MASK after error accesses");
    check_data(o_ctrl, snap_ctrl, "CTRL after error accesses");
    check_count(o_count, snap_count, "COUNT after error accesses");
    report_test("slave errors", mark);

    $display("Tests passed: %0d, failed: %0d, mismatches: %0d", n_pass, n_fail, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
common/regblk_pkg.sv
regblk/apb_decoder.sv
regblk/ctrl_regs.sv
regblk/irq_status.sv
regblk/event_counter.sv
regblk/regblk_top.sv
test/tb_regblk.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f filelist.f --top-module tb_regblk -o sim_regblk

output="$(./obj_dir/sim_regblk)"
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'Done: no errors'; then
  exit 0
fi
exit 1
